/* hw/game_pkg.sv */
// Video subsystem shared types
package game_pkg;

    // Clocks from sdram_addr to data_read
    localparam int SDRAM_LATENCY = 2;

    // Cen cycles from raster position to char pixel
    localparam int PIXEL_DELAY = 8;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       lhbl;   // High while h is visible
        logic       lvbl;   // High while v is visible
        logic       hs;
        logic       vs;
        logic       hinit;  // Line start
    } raster_t;

    typedef enum logic [1:0] {
        SLOT_CHAR,
        SLOT_CPU,
        SLOT_IDLE,
        SLOT_REFRESH
    } rom_slot_e;

    typedef struct packed {
        logic [13:0] addr;  // Word address inside the client region
        logic        cs;
    } rom_req_t;

    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] dout;
        logic       wr;
        logic       rd;
    } cpu_bus_t;

    typedef struct packed {
        logic [3:0] color;
        logic [3:0] pal;
    } pixel_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [7:0]  addr;
        logic [11:0] din;   // {red, green, blue}
        logic        we;
    } prom_prog_t;

    // SDRAM slot owner for the low three H bits
    function automatic rom_slot_e slot_of(input logic [2:0] h3);
        case (h3)
            3'd0, 3'd4: return SLOT_CHAR;
            3'd2:       return SLOT_CPU;
            3'd6:       return SLOT_REFRESH;
            default:    return SLOT_IDLE;
        endcase
    endfunction

endpackage

/* hw/video_timer.sv */
`timescale 1ns/1ps
// Raster timing generator
module video_timer #(
    parameter int H_TOTAL   = 64,
    parameter int H_VISIBLE = 48,
    parameter int V_TOTAL   = 24,
    parameter int V_VISIBLE = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    output game_pkg::raster_t raster
);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    logic       h_wrap;

    assign h_wrap = raster.h == 9'(H_TOTAL - 1);

    // Next beam position, flags below are derived from it
    always_comb begin
        h_nxt = raster.h + 9'd1;
        v_nxt = raster.v;
        if (h_wrap) begin
            h_nxt = '0;
            if (raster.v == 9'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = raster.v + 9'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster.h     <= '0;
            raster.v     <= '0;
            raster.lhbl  <= 1'b1;
            raster.lvbl  <= 1'b1;
            raster.hs    <= 1'b0;
            raster.vs    <= 1'b0;
            raster.hinit <= 1'b0;
        end else if (cen) begin
            raster.h     <= h_nxt;
            raster.v     <= v_nxt;
            raster.lhbl  <= h_nxt < 9'(H_VISIBLE);
            raster.lvbl  <= v_nxt < 9'(V_VISIBLE);
            // Four counts of sync, starting four after the visible area
            raster.hs    <= h_nxt >= 9'(H_VISIBLE + 4) && h_nxt < 9'(H_VISIBLE + 8);
            raster.vs    <= v_nxt == 9'(V_VISIBLE + 2) || v_nxt == 9'(V_VISIBLE + 3);
            raster.hinit <= h_nxt == 9'd0;  // Held for the whole h = 0 count
        end
    end

endmodule

/* hw/rom_slot_arbiter.sv */
`timescale 1ns/1ps
// SDRAM slot arbiter
module rom_slot_arbiter #(
    parameter logic [21:0] CHAR_OFFSET = 22'h0B000,
    parameter logic [21:0] CPU_OFFSET  = 22'h00000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  game_pkg::raster_t  raster,
    input  game_pkg::rom_req_t char_req,
    input  game_pkg::rom_req_t cpu_req,
    input  logic               downloading,
    input  logic [15:0]        data_read,
    output logic [15:0]        char_data,
    output logic [15:0]        cpu_rom_data,
    output logic [21:0]        sdram_addr,
    output logic               autorefresh,
    output logic               rom_ready,
    output logic               rst_game
);

    localparam int LAT = game_pkg::SDRAM_LATENCY;

    game_pkg::rom_slot_e slot;
    game_pkg::rom_slot_e issue_tag;     // Owner of a freshly issued sdram_addr
    game_pkg::rom_slot_e tag_sr [LAT];  // Reads in flight
    logic                rst_aux;

    assign slot        = game_pkg::slot_of(raster.h[2:0]);
    assign autorefresh = rom_ready && slot == game_pkg::SLOT_REFRESH;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_addr <= '0;
            issue_tag  <= game_pkg::SLOT_IDLE;
            for (int i = 0; i < LAT; i++) begin
                tag_sr[i] <= game_pkg::SLOT_IDLE;
            end
        end else begin
            issue_tag <= game_pkg::SLOT_IDLE;
            if (cen && rom_ready) begin
                case (slot)
                    game_pkg::SLOT_CHAR: begin
                        if (char_req.cs) begin
                            sdram_addr <= CHAR_OFFSET + 22'(char_req.addr);
                            issue_tag  <= game_pkg::SLOT_CHAR;
                        end
                    end
                    game_pkg::SLOT_CPU: begin
                        if (cpu_req.cs) begin
                            sdram_addr <= CPU_OFFSET + 22'(cpu_req.addr);
                            issue_tag  <= game_pkg::SLOT_CPU;
                        end
                    end
                    default: ;  // Refresh and idle slots issue nothing
                endcase
            end
            tag_sr[0] <= issue_tag;
            for (int i = 1; i < LAT; i++) begin
                tag_sr[i] <= tag_sr[i-1];
            end
        end
    end

    // Data returns LAT clocks after the new address appears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_data    <= '0;
            cpu_rom_data <= '0;
        end else begin
            if (tag_sr[LAT-1] == game_pkg::SLOT_CHAR) char_data <= data_read;
            if (tag_sr[LAT-1] == game_pkg::SLOT_CPU) cpu_rom_data <= data_read;
        end
    end

    // ROM ready once the download is over
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_ready <= 1'b0;
        end else if (!downloading) begin
            rom_ready <= 1'b1;
        end
    end

    // Game held in reset until ready and two clocks past the download
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {rst_game, rst_aux} <= 2'b11;
        end else if (!rom_ready) begin
            {rst_game, rst_aux} <= 2'b11;
        end else begin
            {rst_game, rst_aux} <= {rst_aux, downloading};
        end
    end

endmodule

/* hw/char_layer.sv */
`timescale 1ns/1ps
// Character tile layer
module char_layer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               rst_game,
    input  game_pkg::raster_t  raster,
    input  game_pkg::cpu_bus_t cpu,
    input  logic [15:0]        char_data,
    output logic [7:0]         cpu_din,
    output game_pkg::rom_req_t char_req,
    output game_pkg::pixel_t   pixel
);

    // Codes in the lower half, attributes in the upper half
    logic [7:0]  ram [1024];
    logic [9:0]  ram_addr;
    logic        cpu_act;
    logic        fetch_code;
    logic        fetch_attr;
    logic [8:0]  tile_idx;
    logic [7:0]  code_q;
    logic [7:0]  attr_q;
    logic [2:0]  row_q;
    logic        req_on;
    logic [15:0] pix_sr;  // Four pixels, leftmost in the top nibble
    logic [3:0]  pal_q;

    assign cpu_act  = cpu.wr | cpu.rd;
    assign tile_idx = {raster.v[7:3], raster.h[6:3]};  // 32 rows of 16 tiles

    // The CPU owns the RAM port whenever it strobes
    assign fetch_code = cen && raster.h[2:0] == 3'd0 && !cpu_act;
    assign fetch_attr = cen && raster.h[2:0] == 3'd1 && !cpu_act;
    assign ram_addr   = cpu_act ? cpu.addr : {raster.h[2:0] == 3'd1, tile_idx};

    always_ff @(posedge clk) begin
        if (cpu.wr) ram[ram_addr] <= cpu.dout;
        if (cpu.rd) cpu_din <= ram[ram_addr];
        if (fetch_code) code_q <= ram[ram_addr];  // Kept as is on a collision
        if (fetch_attr) attr_q <= ram[ram_addr];
    end

    // Both char slots of a column read the same word, code * 8 + row
    assign char_req.addr = {3'b000, code_q, row_q};
    assign char_req.cs   = req_on;

    /*
     * Slot 4 data is loaded at h[2:0] = 7 and the slot 0 data of the next
     * column at h[2:0] = 3, so the tile shows 8 counts after its fetch
     */
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q  <= '0;
            req_on <= 1'b0;
            pix_sr <= '0;
            pal_q  <= '0;
        end else if (rst_game) begin
            req_on <= 1'b0;
            pix_sr <= '0;
            pal_q  <= '0;
        end else if (cen) begin
            if (raster.h[2:0] == 3'd0) begin
                row_q  <= raster.v[2:0];
                req_on <= 1'b1;
            end
            if (raster.h[1:0] == 2'd3) begin
                pix_sr <= char_data;
                if (raster.h[2]) pal_q <= attr_q[3:0];  // New tile starts
            end else begin
                pix_sr <= pix_sr << 4;
            end
        end
    end

    assign pixel.color = pix_sr[15:12];
    assign pixel.pal   = pal_q;

endmodule

/* hw/color_mixer.sv */
`timescale 1ns/1ps
// Palette and colour output
module color_mixer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 rst_game,
    input  game_pkg::raster_t    raster,
    input  game_pkg::pixel_t     pixel,
    input  game_pkg::prom_prog_t prog,
    output game_pkg::rgb_t       rgb
);

    localparam int DLY = game_pkg::PIXEL_DELAY;

    game_pkg::rgb_t prom [256];
    game_pkg::rgb_t entry;
    logic [DLY-1:0] lhbl_dly;
    logic [DLY-1:0] lvbl_dly;
    logic           visible;

    always_ff @(posedge clk) begin
        if (prog.we) prom[prog.addr] <= game_pkg::rgb_t'(prog.din);
    end

    assign entry = prom[{pixel.pal, pixel.color}];

    // Blanking delayed to line up with the char pixel
    assign visible = lhbl_dly[DLY-1] && lvbl_dly[DLY-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_dly <= '0;
            lvbl_dly <= '0;
            rgb      <= '0;
        end else if (cen) begin
            lhbl_dly <= {lhbl_dly[DLY-2:0], raster.lhbl};
            lvbl_dly <= {lvbl_dly[DLY-2:0], raster.lvbl};
            if (rst_game || !visible) begin
                rgb <= '0;
            end else begin
                rgb <= entry;  // One extra count after the pixel
            end
        end
    end

endmodule

/* hw/game_top.sv */
`timescale 1ns/1ps
// Arcade video subsystem top
module game_top #(
    parameter int          H_TOTAL     = 64,
    parameter int          H_VISIBLE   = 48,
    parameter int          V_TOTAL     = 24,
    parameter int          V_VISIBLE   = 16,
    parameter logic [21:0] CHAR_OFFSET = 22'h0B000,
    parameter logic [21:0] CPU_OFFSET  = 22'h00000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,       // Pixel clock enable
    input  game_pkg::cpu_bus_t   cpu,
    input  game_pkg::prom_prog_t prog,
    input  logic                 downloading,
    input  logic [15:0]          data_read,
    output logic [7:0]           cpu_din,
    output game_pkg::rgb_t       rgb,
    output logic                 lhbl,
    output logic                 lvbl,
    output logic                 hs,
    output logic                 vs,
    output logic [21:0]          sdram_addr,
    output logic                 autorefresh,
    output logic                 rom_ready
);

    // No CPU ROM client in this cut
    localparam game_pkg::rom_req_t CPU_REQ_IDLE = '0;

    game_pkg::raster_t  raster;
    game_pkg::rom_req_t char_req;
    game_pkg::pixel_t   pixel;
    logic [15:0]        char_data;
    logic               rst_game;

    assign lhbl = raster.lhbl;
    assign lvbl = raster.lvbl;
    assign hs   = raster.hs;
    assign vs   = raster.vs;

    video_timer #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) timer_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .raster (raster)
    );

    rom_slot_arbiter #(
        .CHAR_OFFSET (CHAR_OFFSET),
        .CPU_OFFSET  (CPU_OFFSET)
    ) rom_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .raster       (raster),
        .char_req     (char_req),
        .cpu_req      (CPU_REQ_IDLE),
        .downloading  (downloading),
        .data_read    (data_read),
        .char_data    (char_data),
        .cpu_rom_data (),
        .sdram_addr   (sdram_addr),
        .autorefresh  (autorefresh),
        .rom_ready    (rom_ready),
        .rst_game     (rst_game)
    );

    char_layer char_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .rst_game  (rst_game),
        .raster    (raster),
        .cpu       (cpu),
        .char_data (char_data),
        .cpu_din   (cpu_din),
        .char_req  (char_req),
        .pixel     (pixel)
    );

    color_mixer mixer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .rst_game (rst_game),
        .raster   (raster),
        .pixel    (pixel),
        .prog     (prog),
        .rgb      (rgb)
    );

endmodule

/* test/game_properties.sv */
`timescale 1ns/1ps
// Raster and slot assertions
module game_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              cen,
    input game_pkg::raster_t raster,
    input logic              autorefresh
);

    // Line start covers only the h = 0 count
    hinit_one_count: assert property (@(posedge clk) disable iff (!rst_n)
        cen && raster.hinit |=> !raster.hinit)
        else $error("hinit held longer than one pixel count");

    refresh_in_slot6: assert property (@(posedge clk) disable iff (!rst_n)
        autorefresh |-> raster.h[2:0] == 3'd6)
        else $error("autorefresh outside slot 6");

    hs_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !(raster.hs && raster.lhbl))
        else $error("hs overlaps the visible area");

endmodule

bind rom_slot_arbiter game_properties props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cen         (cen),
    .raster      (raster),
    .autorefresh (autorefresh)
);

/* test/game_tb.sv */
`timescale 1ns/1ps
// Video subsystem testbench
module game_tb;

    localparam int          H_TOTAL       = 64;
    localparam int          H_VISIBLE     = 48;
    localparam int          V_TOTAL       = 24;
    localparam int          V_VISIBLE     = 16;
    localparam logic [21:0] CHAR_OFFSET   = 22'h0B000;
    localparam logic [31:0] SEED          = 32'h1bd70b6f;
    localparam int          FRAME_CLKS    = 2 * H_TOTAL * V_TOTAL;  // cen every second clk
    localparam int          FILL_CLKS     = 1024 + 256;
    localparam int          WATCHDOG_CLKS = 3 * FRAME_CLKS + 2000 + FILL_CLKS;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cen;
    logic                 downloading;
    logic [15:0]          data_read;
    logic [21:0]          addr_d;
    logic [7:0]           cpu_din;
    logic                 lhbl;
    logic                 lvbl;
    logic                 hs;
    logic                 vs;
    logic [21:0]          sdram_addr;
    logic                 autorefresh;
    logic                 rom_ready;
    logic                 checks_on;
    game_pkg::cpu_bus_t   cpu;
    game_pkg::prom_prog_t prog;
    game_pkg::rgb_t       rgb;
    int                   h_m;             // Beam position model
    int                   v_m;
    logic [7:0]           ram_m [1024];    // Char RAM model
    game_pkg::rgb_t       pal_m [256];     // Palette model

    game_top #(
        .H_TOTAL (H_TOTAL), .H_VISIBLE (H_VISIBLE), .V_TOTAL (V_TOTAL),
        .V_VISIBLE (V_VISIBLE), .CHAR_OFFSET (CHAR_OFFSET), .CPU_OFFSET (22'h00000)
    ) dut_i (
        .clk (clk), .rst_n (rst_n), .cen (cen), .cpu (cpu), .prog (prog),
        .downloading (downloading), .data_read (data_read), .cpu_din (cpu_din),
        .rgb (rgb), .lhbl (lhbl), .lvbl (lvbl), .hs (hs), .vs (vs),
        .sdram_addr (sdram_addr), .autorefresh (autorefresh), .rom_ready (rom_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cen <= ~cen;  // Pixel cycle every second clk

    // SDRAM with two cycles of latency
    always @(posedge clk) begin
        addr_d    <= sdram_addr;
        data_read <= rom_word(addr_d);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_m <= 0;
            v_m <= 0;
        end else if (cen) begin
            h_m <= (h_m == H_TOTAL - 1) ? 0 : h_m + 1;
            if (h_m == H_TOTAL - 1) v_m <= (v_m == V_TOTAL - 1) ? 0 : v_m + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [15:0] rom_word(input logic [21:0] a);
        logic [31:0] x;
        x = xorshift(SEED ^ {10'd0, a});
        return x[15:0];
    endfunction

    // ROM word of column c on line v
    function automatic logic [21:0] tile_addr(input int c, input int v);
        int idx;
        idx = (v / 8) * 16 + c;
        return CHAR_OFFSET + 22'({ram_m[10'(idx)], 3'(v % 8)});
    endfunction

    function automatic game_pkg::rgb_t pixel_rgb(input int x, input int y);
        logic [7:0]  attr;
        logic [15:0] w;
        logic [3:0]  nib;
        attr = ram_m[10'(512 + (y / 8) * 16 + x / 8)];
        w    = rom_word(tile_addr(x / 8, y));
        nib  = w[15 - 4 * (x % 4) -: 4];  // Same word fills both halves of a tile
        return pal_m[{attr[3:0], nib}];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) fail_run($sformatf("Error at %0d ns: %s is %b, expected %b",
                                            $time, name, got, exp));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
        if (got !== exp) fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                                            $time, name, got, exp));
    endtask

    task automatic check_addr(input logic [21:0] got, input logic [21:0] exp, input string name);
        if (got !== exp) fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                                            $time, name, got, exp));
    endtask

    task automatic check_rgb(input game_pkg::rgb_t got, input game_pkg::rgb_t exp,
                             input string name);
        if (got !== exp) fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
                                            $time, name, got, exp));
    endtask

    task automatic cpu_write(input logic [9:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu.addr <= a;
        cpu.dout <= d;
        cpu.wr   <= 1'b1;
        cpu.rd   <= 1'b0;
        ram_m[a] = d;
    endtask

    task automatic cpu_read(input logic [9:0] a, input logic [7:0] exp);
        @(posedge clk);
        cpu.addr <= a;
        cpu.wr   <= 1'b0;
        cpu.rd   <= 1'b1;
        @(posedge clk);
        cpu <= '0;
        @(negedge clk);
        check_byte(cpu_din, exp, "cpu_din");
    endtask

    task automatic prom_write(input logic [7:0] a, input logic [11:0] d);
        @(posedge clk);
        prog.addr <= a;
        prog.din  <= d;
        prog.we   <= 1'b1;
        pal_m[a] = game_pkg::rgb_t'(d);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        cpu  <= '0;
        prog <= '0;
    endtask

    // Per-cycle checks against the beam model
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag(lhbl, h_m < H_VISIBLE, "lhbl");
            check_flag(lvbl, v_m < V_VISIBLE, "lvbl");
            check_flag(hs, h_m >= H_VISIBLE + 4 && h_m < H_VISIBLE + 8, "hs");
            check_flag(vs, v_m == V_VISIBLE + 2 || v_m == V_VISIBLE + 3, "vs");
            if (checks_on) begin
                check_flag(autorefresh, h_m % 8 == 6, "autorefresh");
                if (h_m % 8 == 5) check_addr(sdram_addr, tile_addr(h_m / 8, v_m), "sdram_addr");
                if (h_m >= 9 && h_m < H_VISIBLE + 9 && v_m < V_VISIBLE) begin
                    check_rgb(rgb, pixel_rgb(h_m - 9, v_m), "rgb");
                end else begin
                    check_rgb(rgb, '0, "rgb");
                end
            end else if (downloading) begin
                check_flag(rom_ready, 1'b0, "rom_ready");
                check_flag(autorefresh, 1'b0, "autorefresh");
                check_addr(sdram_addr, '0, "sdram_addr");
                check_rgb(rgb, '0, "rgb");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        fail_run("Watchdog timeout, the run did not finish in time");
    end

    initial begin
        string      ops [$];
        int         fa [$];
        int         fb [$];
        string      line;
        string      op;
        int         fd;
        int         a;
        int         b;
        logic [7:0] pa;
        rst_n = 1'b0;
        cen = 1'b0;
        cpu = '0;
        prog = '0;
        downloading = 1'b1;
        data_read = '0;
        addr_d = '0;
        checks_on = 1'b0;
        fd = $fopen("test/game_patterns.txt", "r");
        if (fd == 0) fail_run("Could not open test/game_patterns.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 2 && line[0] != "#") begin
                void'($sscanf(line, "%s %h %h", op, a, b));
                ops.push_back(op);
                fa.push_back(a);
                fb.push_back(b);
            end
        end
        $fclose(fd);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // Video stays dark while the ROM loads
        repeat (200) @(negedge clk);
        for (int i = 0; i < 1024; i++) cpu_write(10'(i), 8'(i) ^ {4{2'(i >> 8)}});
        bus_idle();
        for (int i = 0; i < 256; i++) begin
            pa = 8'(i);
            prom_write(pa, {pa[3:0] ^ pa[7:4], pa[7:4], ~pa[3:0]});
        end
        foreach (ops[i]) begin
            case (ops[i])
                "W": cpu_write(10'(fa[i]), 8'(fb[i]));
                "R": cpu_read(10'(fa[i]), 8'(fb[i]));
                "P": prom_write(8'(fa[i]), 12'(fb[i]));
                default: ;
            endcase
        end
        bus_idle();
        @(posedge clk);
        downloading <= 1'b0;
        for (int i = 0; i < 4 && !rom_ready; i++) @(negedge clk);
        if (!rom_ready) fail_run("rom_ready did not rise after the download ended");
        // Start checking on a fresh frame
        @(negedge clk);
        while (h_m == 0 && v_m == 0) @(negedge clk);
        while (h_m != 0 || v_m != 0) @(negedge clk);
        checks_on = 1'b1;
        foreach (ops[i]) begin
            if (ops[i] == "X") begin
                @(negedge clk);
                while (!(h_m == fa[i] + 9 && v_m == fb[i])) @(negedge clk);
                check_rgb(rgb, pixel_rgb(fa[i], fb[i]), "rgb");
            end
        end
        repeat (FRAME_CLKS) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* test/game_patterns.txt */
# op addr data: W and R char RAM address and byte, P palette address and 12-bit colour
# X pixel column and line, colour comes from the ROM model and the palette
W 000 03
W 001 7f
W 005 c2
W 010 44
W 015 a9
W 200 01
W 201 02
W 205 0f
W 210 13
W 215 0e
R 000 03
R 005 c2
R 210 13
W 3ff 66
R 3ff 66
P 10 f00
P 1f 0f0
P 2a 123
P f5 abc
X 00 00
X 05 02
X 0c 07
X 2f 07
X 00 08
X 17 0b
X 2f 0f

/* game_top.f */
hw/game_pkg.sv
hw/video_timer.sv
hw/rom_slot_arbiter.sv
hw/char_layer.sv
hw/color_mixer.sv
hw/game_top.sv
test/game_properties.sv
test/game_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module game_tb -f game_top.f -o game_sim
./obj_dir/game_sim
